// ==== flist.f ====
hdl/snn_pkg.sv
hdl/register_bank.sv
hdl/synapse_sequencer.sv
hdl/neuron_lane.sv
hdl/current_collector.sv
hdl/snn_core_top.sv
test/snn_core_tb.sv

// ==== hdl/current_collector.sv ====
`timescale 1ns/10ps
`default_nettype none

module current_collector
    import snn_pkg::*;
(
    input  logic         clk,
    input  logic         reset,

    // Step stream, observed alongside the lanes
    input  logic         step_valid,
    input  logic         step_last,
    input  logic         step_clear,
    output logic         step_ready,
    input  current_vec_t lane_currents,

    // Response port
    output logic         rsp_valid,
    input  logic         rsp_ready,
    output current_vec_t rsp_currents
);

    logic snap_pending;                         // Lanes settle this cycle, latch next edge
    logic rsp_hold;                             // Response waiting and not read now

    assign rsp_hold = rsp_valid && !rsp_ready;

    // Only the final step is stalled, so earlier steps keep flowing
    assign step_ready = !step_last || !rsp_hold;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            snap_pending <= 1'b0;
            rsp_valid    <= 1'b0;
        end else begin
            snap_pending <= step_valid && step_ready && step_last && !step_clear;
            if (snap_pending) begin
                rsp_valid <= 1'b1;
            end else if (rsp_valid && rsp_ready) begin
                rsp_valid <= 1'b0;              // Drained
            end
        end
    end

    always_ff @(posedge clk) begin
        if (snap_pending) begin
            rsp_currents <= lane_currents;      // Snapshot of all lanes
        end
    end

    a_rsp_stable: assert property (
        @(posedge clk) disable iff (reset)
        (rsp_valid && !rsp_ready) |=> $stable(rsp_currents)
    ) else $error("rsp_currents changed while response stalled");

    // A snapshot must never land on top of an unread response
    a_no_overwrite: assert property (
        @(posedge clk) disable iff (reset)
        snap_pending |-> !rsp_valid
    ) else $error("response overwritten before it was read");

endmodule

`default_nettype wire

// ==== hdl/neuron_lane.sv ====
`timescale 1ns/10ps
`default_nettype none

module neuron_lane
    import snn_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     step_fire,                 // Step consumed this cycle
    input  logic     step_spike,                // Spike on synapse k
    input  logic     step_clear,
    input  weight_t  weight,                    // Weight from synapse k to this lane
    output current_t current
);

    weight_t               gated_weight;
    logic [CURRENT_BITS:0] sum;                 // One spare bit for the carry
    logic                  overflow;

    // Spike gates the weight into the sum
    assign gated_weight = step_spike ? weight : '0;

    assign sum = {1'b0, current}
               + {{(CURRENT_BITS + 1 - WEIGHT_BITS){1'b0}}, gated_weight};

    assign overflow = (sum > {1'b0, CURRENT_MAX});

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            current <= '0;
        end else if (step_fire) begin
            if (step_clear) begin
                current <= '0;                  // Clear step wins over any spike
            end else if (overflow) begin
                current <= CURRENT_MAX;         // Saturate, never wrap
            end else begin
                current <= sum[CURRENT_BITS-1:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/register_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

module register_bank #(
    parameter int DEPTH = 16,
    parameter int WIDTH = 32
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_index,
    input  logic [WIDTH-1:0]         wr_data,
    input  logic [$clog2(DEPTH)-1:0] rd_index,
    output logic [WIDTH-1:0]         rd_data
);

    logic [WIDTH-1:0] mem [DEPTH];

    // Banks must read as zero straight after reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[wr_index] <= wr_data;           // Store by index
        end
    end

    assign rd_data = mem[rd_index];             // Combinational read

    a_wr_index_in_range: assert property (
        @(posedge clk) disable iff (reset)
        wr_en |-> (int'(wr_index) < DEPTH)
    ) else $error("register_bank write index %0d beyond depth %0d", wr_index, DEPTH);

endmodule

`default_nettype wire

// ==== hdl/snn_core_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module snn_core_top
    import snn_pkg::*;
(
    input  logic         clk,
    input  logic         reset,

    input  logic         cmd_valid,
    output logic         cmd_ready,
    input  op_t          cmd_op,
    input  cmd_index_t   cmd_index,
    input  spike_word_t  cmd_data,

    output logic         rsp_valid,
    input  logic         rsp_ready,
    output current_vec_t rsp_currents
);

    logic                          spike_wr_en;
    logic [$clog2(SPIKE_REGS)-1:0] spike_wr_index;
    spike_word_t                   spike_wr_data;
    logic [$clog2(SPIKE_REGS)-1:0] spike_rd_index;
    spike_word_t                   spike_rd_data;

    logic                          weight_wr_en;
    cmd_index_t                    weight_wr_index;
    weight_word_t                  weight_wr_data;
    cmd_index_t                    weight_rd_index;
    weight_word_t                  weight_rd_data;

    logic                          step_valid;
    logic                          step_ready;
    logic                          step_spike;
    weight_word_t                  step_weights;
    logic                          step_clear;
    logic                          step_last;
    logic                          step_fire;
    current_vec_t                  lane_currents;

    assign step_fire = step_valid && step_ready;   // Shared by every lane

    synapse_sequencer u_sequencer (
        .clk             (clk),
        .reset           (reset),
        .cmd_valid       (cmd_valid),
        .cmd_ready       (cmd_ready),
        .cmd_op          (cmd_op),
        .cmd_index       (cmd_index),
        .cmd_data        (cmd_data),
        .spike_wr_en     (spike_wr_en),
        .spike_wr_index  (spike_wr_index),
        .spike_wr_data   (spike_wr_data),
        .spike_rd_index  (spike_rd_index),
        .spike_rd_data   (spike_rd_data),
        .weight_wr_en    (weight_wr_en),
        .weight_wr_index (weight_wr_index),
        .weight_wr_data  (weight_wr_data),
        .weight_rd_index (weight_rd_index),
        .weight_rd_data  (weight_rd_data),
        .step_valid      (step_valid),
        .step_spike      (step_spike),
        .step_weights    (step_weights),
        .step_clear      (step_clear),
        .step_last       (step_last),
        .step_ready      (step_ready)
    );

    register_bank #(.DEPTH(SPIKE_REGS), .WIDTH($bits(spike_word_t))) u_spike_bank (
        .clk      (clk),
        .reset    (reset),
        .wr_en    (spike_wr_en),
        .wr_index (spike_wr_index),
        .wr_data  (spike_wr_data),
        .rd_index (spike_rd_index),
        .rd_data  (spike_rd_data)
    );

    register_bank #(.DEPTH(SYNAPSES), .WIDTH($bits(weight_word_t))) u_weight_bank (
        .clk      (clk),
        .reset    (reset),
        .wr_en    (weight_wr_en),
        .wr_index (weight_wr_index),
        .wr_data  (weight_wr_data),
        .rd_index (weight_rd_index),
        .rd_data  (weight_rd_data)
    );

    // Nibble i of the weight word feeds lane i
    for (genvar i = 0; i < LANE_COUNT; i++) begin : g_lane
        neuron_lane u_lane (
            .clk        (clk),
            .reset      (reset),
            .step_fire  (step_fire),
            .step_spike (step_spike),
            .step_clear (step_clear),
            .weight     (step_weights[i*WEIGHT_BITS +: WEIGHT_BITS]),
            .current    (lane_currents[i*CURRENT_BITS +: CURRENT_BITS])
        );
    end

    current_collector u_collector (
        .clk           (clk),
        .reset         (reset),
        .step_valid    (step_valid),
        .step_last     (step_last),
        .step_clear    (step_clear),
        .step_ready    (step_ready),
        .lane_currents (lane_currents),
        .rsp_valid     (rsp_valid),
        .rsp_ready     (rsp_ready),
        .rsp_currents  (rsp_currents)
    );

endmodule

`default_nettype wire

// ==== hdl/snn_pkg.sv ====
`default_nettype none

package snn_pkg;

    // Core sizes
    localparam int LANE_COUNT   = 8;    // Neuron lanes in the core
    localparam int SPIKE_REGS   = 16;   // Words in the spike bank
    localparam int SYNAPSES     = 32;   // Spikes per word, also words in the weight bank
    localparam int WEIGHT_BITS  = 4;
    localparam int CURRENT_BITS = 12;

    // Bit k is the spike on synapse k
    typedef logic [SYNAPSES-1:0] spike_word_t;

    // Nibble i is the weight from one synapse to lane i
    typedef logic [LANE_COUNT*WEIGHT_BITS-1:0] weight_word_t;

    typedef logic [WEIGHT_BITS-1:0]             weight_t;
    typedef logic [CURRENT_BITS-1:0]            current_t;
    typedef logic [LANE_COUNT*CURRENT_BITS-1:0] current_vec_t;   // Lane i in slice i
    typedef logic [$clog2(SYNAPSES)-1:0]        cmd_index_t;
    typedef logic [1:0]                         op_t;

    localparam current_t CURRENT_MAX = {CURRENT_BITS{1'b1}};     // Saturation point, 4095

    // Command opcodes
    localparam op_t OP_STORE_SPIKE  = 2'd0;
    localparam op_t OP_STORE_WEIGHT = 2'd1;
    localparam op_t OP_CLEAR        = 2'd2;   // Zero all lane currents
    localparam op_t OP_ACCUMULATE   = 2'd3;   // Walk one spike word

    typedef enum logic {
        SEQ_IDLE,                             // Taking commands
        SEQ_STREAM                            // Emitting steps to the lanes
    } seq_state_t;

endpackage

`default_nettype wire

// ==== hdl/synapse_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module synapse_sequencer
    import snn_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset,

    // Command port
    input  logic                          cmd_valid,
    output logic                          cmd_ready,
    input  op_t                           cmd_op,
    input  cmd_index_t                    cmd_index,
    input  spike_word_t                   cmd_data,

    // Spike bank
    output logic                          spike_wr_en,
    output logic [$clog2(SPIKE_REGS)-1:0] spike_wr_index,
    output spike_word_t                   spike_wr_data,
    output logic [$clog2(SPIKE_REGS)-1:0] spike_rd_index,
    input  spike_word_t                   spike_rd_data,

    // Weight bank
    output logic                          weight_wr_en,
    output cmd_index_t                    weight_wr_index,
    output weight_word_t                  weight_wr_data,
    output cmd_index_t                    weight_rd_index,
    input  weight_word_t                  weight_rd_data,

    // Step stream to lanes and collector
    output logic                          step_valid,
    output logic                          step_spike,
    output weight_word_t                  step_weights,
    output logic                          step_clear,
    output logic                          step_last,
    input  logic                          step_ready
);

    seq_state_t  state;
    spike_word_t spike_latch;                   // Spike word under accumulation
    cmd_index_t  syn_count;                     // Synapse k of the current step
    logic        clear_flag;                    // Stream is a single clear step
    logic        cmd_take;
    logic        step_take;
    logic        starts_stream;

    assign cmd_ready     = (state == SEQ_IDLE);
    assign cmd_take      = cmd_valid && cmd_ready;
    assign step_take     = step_valid && step_ready;
    assign starts_stream = cmd_take && ((cmd_op == OP_CLEAR) || (cmd_op == OP_ACCUMULATE));

    // Stores go straight to the banks on the accepting edge
    assign spike_wr_en     = cmd_take && (cmd_op == OP_STORE_SPIKE);
    assign spike_wr_index  = cmd_index[$clog2(SPIKE_REGS)-1:0];   // Wraps modulo 16
    assign spike_wr_data   = cmd_data;
    assign spike_rd_index  = cmd_index[$clog2(SPIKE_REGS)-1:0];

    assign weight_wr_en    = cmd_take && (cmd_op == OP_STORE_WEIGHT);
    assign weight_wr_index = cmd_index;                           // Full 5 bits
    assign weight_wr_data  = cmd_data;
    assign weight_rd_index = syn_count;                           // Weight word k

    assign step_valid   = (state == SEQ_STREAM);
    assign step_spike   = spike_latch[syn_count] && !clear_flag;
    assign step_weights = weight_rd_data;
    assign step_clear   = clear_flag;
    assign step_last    = clear_flag || (syn_count == cmd_index_t'(SYNAPSES - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= SEQ_IDLE;
            syn_count  <= '0;
            clear_flag <= 1'b0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (starts_stream) begin
                        state      <= SEQ_STREAM;
                        syn_count  <= '0;
                        clear_flag <= (cmd_op == OP_CLEAR);
                    end
                end
                SEQ_STREAM: begin
                    if (step_take) begin
                        if (step_last) begin
                            state <= SEQ_IDLE;      // Back to commands
                        end else begin
                            syn_count <= syn_count + 1'b1;
                        end
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // Spike word held for the whole walk
    always_ff @(posedge clk) begin
        if (cmd_take && (cmd_op == OP_ACCUMULATE)) begin
            spike_latch <= spike_rd_data;
        end
    end

    a_step_held: assert property (
        @(posedge clk) disable iff (reset)
        (step_valid && !step_ready) |=> (step_valid && $stable(step_spike)
            && $stable(step_weights) && $stable(step_clear) && $stable(step_last))
    ) else $error("step changed while stalled");

    a_cmd_after_last: assert property (
        @(posedge clk) disable iff (reset)
        $rose(cmd_ready) |-> $past(step_valid && step_ready && step_last)
    ) else $error("cmd_ready rose before the last step was consumed");

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SNN core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module snn_core_tb -f flist.f -o snn_sim

sim_out=$(./obj_dir/snn_sim 2>&1 || true)
echo "$sim_out"

if echo "$sim_out" | grep -qx "TB PASSED"; then
    exit 0
fi
exit 1

// ==== test/snn_cases.txt ====
# Columns: case name, opcode (0 spike, 1 weight, 2 clear, 3 accumulate), index, data in hex,
# expected packed currents in hex with lane 7 leftmost, checked on accumulate lines only
reset_zero    3  0 00000000 000000000000000000000000
store_w0      1  0 87654321 0
store_w5      1  5 1f2e3d4c 0
store_w31     1 31 a5a5a5a5 0
store_s1      0  1 00000001 0
single_w0     3  1 00000000 008007006005004003002001
store_s18     0 18 00000020 0
wrap_s2       3  2 00000000 00901600801300701000600d
wrap_s18      3 18 00000000 00a02500a02100a01d00a019
clear_a       2  0 00000000 0
store_s3      0  3 80000021 0
multi_first   3  3 00000000 01301b012018011015010012
multi_second  3  3 00000000 02603602403002202a020024
sat_w00       1  0 ffffffff 0
sat_w01       1  1 ffffffff 0
sat_w02       1  2 ffffffff 0
sat_w03       1  3 ffffffff 0
sat_w04       1  4 ffffffff 0
sat_w05       1  5 ffffffff 0
sat_w06       1  6 ffffffff 0
sat_w07       1  7 ffffffff 0
sat_w08       1  8 ffffffff 0
sat_w09       1  9 ffffffff 0
sat_w10       1 10 ffffffff 0
sat_w11       1 11 ffffffff 0
sat_w12       1 12 ffffffff 0
sat_w13       1 13 ffffffff 0
sat_w14       1 14 ffffffff 0
sat_w15       1 15 ffffffff 0
sat_w16       1 16 ffffffff 0
sat_w17       1 17 ffffffff 0
sat_w18       1 18 ffffffff 0
sat_w19       1 19 ffffffff 0
sat_w20       1 20 ffffffff 0
sat_w21       1 21 ffffffff 0
sat_w22       1 22 ffffffff 0
sat_w23       1 23 ffffffff 0
sat_w24       1 24 ffffffff 0
sat_w25       1 25 ffffffff 0
sat_w26       1 26 ffffffff 0
sat_w27       1 27 ffffffff 0
sat_w28       1 28 ffffffff 0
sat_w29       1 29 ffffffff 0
sat_w30       1 30 ffffffff 0
sat_w31       1 31 ffffffff 0
store_s4      0  4 ffffffff 0
clear_b       2  0 00000000 0
sat_acc01     3  4 00000000 1e01e01e01e01e01e01e01e0
sat_acc02     3  4 00000000 3c03c03c03c03c03c03c03c0
sat_acc03     3  4 00000000 5a05a05a05a05a05a05a05a0
sat_acc04     3  4 00000000 780780780780780780780780
sat_acc05     3  4 00000000 960960960960960960960960
sat_acc06     3  4 00000000 b40b40b40b40b40b40b40b40
sat_acc07     3  4 00000000 d20d20d20d20d20d20d20d20
sat_acc08     3  4 00000000 f00f00f00f00f00f00f00f00
sat_acc09     3  4 00000000 ffffffffffffffffffffffff
sat_acc10     3  4 00000000 ffffffffffffffffffffffff

// ==== test/snn_core_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module snn_core_tb
    import snn_pkg::*;
;

    localparam int CMD_TIMEOUT = 200;           // Cycles a command may wait for cmd_ready
    localparam int RSP_TIMEOUT = 1000;          // Cycles to drain the last responses

    logic         clk;
    logic         reset;
    logic         cmd_valid;
    logic         cmd_ready;
    op_t          cmd_op;
    cmd_index_t   cmd_index;
    spike_word_t  cmd_data;
    logic         rsp_valid;
    logic         rsp_ready;
    current_vec_t rsp_currents;

    string        name_q[$];                    // Accumulate case names in command order
    current_vec_t exp_q[$];                     // Matching expected currents
    string        rsp_name;
    current_vec_t rsp_expected;
    int           rsp_count;

    snn_core_top DUT (
        .clk          (clk),
        .reset        (reset),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .cmd_op       (cmd_op),
        .cmd_index    (cmd_index),
        .cmd_data     (cmd_data),
        .rsp_valid    (rsp_valid),
        .rsp_ready    (rsp_ready),
        .rsp_currents (rsp_currents)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                 // 100 ns period
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input current_vec_t expected,
                               input current_vec_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // Holds the command until cmd_ready is seen, then drops valid after the taking edge
    task automatic send_command(input string name, input int op, input int idx,
                                input logic [31:0] data, input current_vec_t expected);
        int waited;
        waited    = 0;
        cmd_valid = 1'b1;
        cmd_op    = op[1:0];
        cmd_index = idx[4:0];
        cmd_data  = data;
        @(negedge clk);
        while (!cmd_ready) begin
            waited++;
            if (waited > CMD_TIMEOUT) begin
                abort_run($sformatf("Timeout: cmd_ready stayed low for case %s", name));
            end
            @(negedge clk);
        end
        if (op == int'(OP_ACCUMULATE)) begin
            name_q.push_back(name);
            exp_q.push_back(expected);
        end
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
    endtask

    // Random stalls on the response port
    always @(posedge clk) begin
        #1;
        rsp_ready = ($urandom % 3) != 0;
    end

    // Sampled mid-cycle, a handshake here completes on the next rising edge
    always @(negedge clk) begin
        if (!reset && rsp_valid && rsp_ready) begin
            if (exp_q.size() == 0) begin
                abort_run("Response arrived with no accumulate waiting for it");
            end else begin
                rsp_name     = name_q.pop_front();
                rsp_expected = exp_q.pop_front();
                check_value(rsp_name, rsp_expected, rsp_currents);
                rsp_count++;
            end
        end
    end

    initial begin : main_flow
        int           fd;
        int           got;
        int           n;
        int           op;
        int           idx;
        int           acc_total;
        int           waited;
        string        line;
        string        name;
        logic [31:0]  data;
        current_vec_t expected;

        void'($urandom(32'h7b83));
        reset     = 1'b1;
        cmd_valid = 1'b0;
        cmd_op    = '0;
        cmd_index = '0;
        cmd_data  = '0;
        rsp_ready = 1'b0;
        rsp_count = 0;
        acc_total = 0;

        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        fd = $fopen("test/snn_cases.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the case file test/snn_cases.txt");
        end
        while (!$feof(fd)) begin
            got = $fgets(line, fd);
            if (got == 0 || line.len() < 2 || line[0] == "#") begin
                continue;                       // Blank or comment line
            end
            n = $sscanf(line, "%s %d %d %h %h", name, op, idx, data, expected);
            if (n != 5) begin
                abort_run({"Malformed line in the case file: ", line});
            end
            send_command(name, op, idx, data, expected);
            if (op == int'(OP_ACCUMULATE)) begin
                acc_total++;
            end
        end
        $fclose(fd);

        waited = 0;
        while (rsp_count < acc_total || !cmd_ready) begin
            waited++;
            if (waited > RSP_TIMEOUT) begin
                abort_run($sformatf("Timeout: only %0d of %0d responses arrived",
                                    rsp_count, acc_total));
            end
            @(negedge clk);
        end

        // Quiet window, any extra response is caught by the monitor
        repeat (20) @(negedge clk);

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire
